// ==== hw/isa_pkg.sv ====
package isa_pkg;

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;

    // Major opcodes the core executes
    typedef enum logic [6:0]
    {
        OP     = 7'b0110011,
        OP_IMM = 7'b0010011,
        LUI    = 7'b0110111,
        BRANCH = 7'b1100011
    } opcode_e;

    typedef enum logic [3:0]
    {
        ADD,
        SUB,
        AND,
        OR,
        XOR,
        SLT,
        SLTU,
        SLL,
        SRL,
        SRA,
        PASS_B      // Operand B straight through, for LUI
    } alu_op_e;

    // NONE marks every instruction that is not a conditional branch
    typedef enum logic [2:0]
    {
        NONE,
        BEQ,
        BNE,
        BLT,
        BGE,
        BLTU,
        BGEU
    } branch_e;

endpackage

// ==== hw/pipe_pkg.sv ====
package pipe_pkg;

    localparam int IMEM_ADDR_W = 8;
    localparam int BTB_INDEX_W = 4;
    localparam int BTB_ENTRIES = 2 ** BTB_INDEX_W;
    // PC bits above the index and the byte offset
    localparam int BTB_TAG_W   = isa_pkg::XLEN - BTB_INDEX_W - 2;

    typedef struct packed
    {
        logic                     en;
        logic [IMEM_ADDR_W-1:0]   addr;
        logic [isa_pkg::XLEN-1:0] data;
    } imem_write_t;

    // Fetched word with the prediction made for it
    typedef struct packed
    {
        logic                     valid;
        logic [isa_pkg::XLEN-1:0] pc;
        logic [isa_pkg::XLEN-1:0] instr;
        logic                     pred_taken;
        logic [isa_pkg::XLEN-1:0] pred_target;
    } fetch_t;

    typedef struct packed
    {
        logic                           valid;
        logic [isa_pkg::XLEN-1:0]       pc;
        isa_pkg::alu_op_e               alu_op;
        isa_pkg::branch_e               branch;
        logic [isa_pkg::REG_ADDR_W-1:0] rs1;
        logic [isa_pkg::REG_ADDR_W-1:0] rs2;
        logic [isa_pkg::XLEN-1:0]       rs1_data;
        logic [isa_pkg::XLEN-1:0]       rs2_data;
        logic [isa_pkg::XLEN-1:0]       imm;
        logic                           use_imm;
        logic [isa_pkg::REG_ADDR_W-1:0] rd;
        logic                           reg_write;
        logic                           pred_taken;
        logic [isa_pkg::XLEN-1:0]       pred_target;
    } id_ex_t;

    typedef struct packed
    {
        logic                           valid;
        logic [isa_pkg::REG_ADDR_W-1:0] rd;
        logic [isa_pkg::XLEN-1:0]       result;
    } ex_wb_t;

    typedef struct packed
    {
        logic                     valid;
        logic [isa_pkg::XLEN-1:0] target;
    } redirect_t;

    typedef struct packed
    {
        logic                     valid;
        logic [isa_pkg::XLEN-1:0] pc;
        logic                     taken;
        logic [isa_pkg::XLEN-1:0] target;
        logic                     mispredict;
    } bp_update_t;

endpackage

// ==== hw/branch_predictor.sv ====
`timescale 1ns/10ps

module branch_predictor
(
    input  logic                     CPU_CLK,
    input  logic                     CPU_RST,
    input  logic [isa_pkg::XLEN-1:0] lookup_pc,
    output logic                     pred_taken,
    output logic [isa_pkg::XLEN-1:0] pred_target,
    input  pipe_pkg::bp_update_t     bp_update,
    output logic [31:0]              branch_count,
    output logic [31:0]              mispredict_count
);
    import isa_pkg::*;
    import pipe_pkg::*;

    logic [BTB_ENTRIES-1:0] btb_valid;
    logic [BTB_TAG_W-1:0]   btb_tag [BTB_ENTRIES];
    logic [XLEN-1:0]        btb_target [BTB_ENTRIES];
    logic [1:0]             history [BTB_ENTRIES];

    logic [BTB_INDEX_W-1:0] lk_idx;
    logic [BTB_TAG_W-1:0]   lk_tag;
    logic [BTB_INDEX_W-1:0] up_idx;
    logic [BTB_TAG_W-1:0]   up_tag;
    logic                   up_hit;

    // ------------------------------
    // Lookup
    // ------------------------------
    assign lk_idx = lookup_pc[BTB_INDEX_W+1:2];
    assign lk_tag = lookup_pc[XLEN-1:BTB_INDEX_W+2];

    // Taken needs a hit and a counter of 2 or 3
    assign pred_taken  = btb_valid[lk_idx] && (btb_tag[lk_idx] == lk_tag) && history[lk_idx][1];
    assign pred_target = btb_target[lk_idx];

    // ------------------------------
    // Update from EX
    // ------------------------------
    assign up_idx = bp_update.pc[BTB_INDEX_W+1:2];
    assign up_tag = bp_update.pc[XLEN-1:BTB_INDEX_W+2];
    assign up_hit = btb_valid[up_idx] && (btb_tag[up_idx] == up_tag);

    always_ff @(posedge CPU_CLK or posedge CPU_RST)
    begin
        if (CPU_RST)
        begin
            btb_valid <= '0;
            for (int i = 0; i < BTB_ENTRIES; i++)
                history[i] <= 2'd0;
        end
        else if (bp_update.valid)
        begin
            if (bp_update.taken && !up_hit)
            begin
                btb_valid[up_idx] <= 1'b1;
                history[up_idx]   <= 2'd2;
            end
            else if (bp_update.taken && history[up_idx] != 2'd3)
                history[up_idx] <= history[up_idx] + 2'd1;
            else if (!bp_update.taken && up_hit && history[up_idx] != 2'd0)
                history[up_idx] <= history[up_idx] - 2'd1;
        end
    end

    // Tag and target follow every taken outcome
    always_ff @(posedge CPU_CLK)
    begin
        if (bp_update.valid && bp_update.taken)
        begin
            btb_tag[up_idx]    <= up_tag;
            btb_target[up_idx] <= bp_update.target;
        end
    end

    // Statistics
    always_ff @(posedge CPU_CLK or posedge CPU_RST)
    begin
        if (CPU_RST)
        begin
            branch_count     <= '0;
            mispredict_count <= '0;
        end
        else if (bp_update.valid)
        begin
            branch_count <= branch_count + 32'd1;
            if (bp_update.mispredict)
                mispredict_count <= mispredict_count + 32'd1;
        end
    end

endmodule

// ==== hw/fetch_unit.sv ====
`timescale 1ns/10ps

module fetch_unit
(
    input  logic                   CPU_CLK,
    input  logic                   CPU_RST,
    input  pipe_pkg::imem_write_t  imem_wr,
    input  pipe_pkg::redirect_t    redirect,
    input  pipe_pkg::bp_update_t   bp_update,
    output pipe_pkg::fetch_t       fetch,
    output logic [31:0]            branch_count,
    output logic [31:0]            mispredict_count
);
    import isa_pkg::*;
    import pipe_pkg::*;

    logic [XLEN-1:0] imem [2**IMEM_ADDR_W];
    logic [XLEN-1:0] pc;
    logic [XLEN-1:0] next_pc;
    logic            pred_taken;
    logic [XLEN-1:0] pred_target;

    branch_predictor branch_predictor_i
    (
        .CPU_CLK          (CPU_CLK),
        .CPU_RST          (CPU_RST),
        .lookup_pc        (pc),
        .pred_taken       (pred_taken),
        .pred_target      (pred_target),
        .bp_update        (bp_update),
        .branch_count     (branch_count),
        .mispredict_count (mispredict_count)
    );

    // Redirect from EX wins over the prediction
    assign next_pc = redirect.valid ? redirect.target :
                     pred_taken     ? pred_target    : pc + 32'd4;

    // Debug write port, usable while the core is held in reset
    always_ff @(posedge CPU_CLK)
    begin
        if (imem_wr.en)
            imem[imem_wr.addr] <= imem_wr.data;
    end

    // PC and the IF/ID register
    always_ff @(posedge CPU_CLK or posedge CPU_RST)
    begin
        if (CPU_RST)
        begin
            pc          <= '0;
            fetch.valid <= 1'b0;
        end
        else
        begin
            pc                <= next_pc;
            fetch.valid       <= !redirect.valid;
            fetch.pc          <= pc;
            fetch.instr       <= imem[pc[IMEM_ADDR_W+1:2]];
            fetch.pred_taken  <= pred_taken;
            fetch.pred_target <= pred_target;
        end
    end

endmodule

// ==== hw/decode_unit.sv ====
`timescale 1ns/10ps

module decode_unit
(
    input  logic                           CPU_CLK,
    input  logic                           CPU_RST,
    input  pipe_pkg::fetch_t               fetch,
    input  pipe_pkg::redirect_t            redirect,
    output logic [isa_pkg::REG_ADDR_W-1:0] rs1_addr,
    output logic [isa_pkg::REG_ADDR_W-1:0] rs2_addr,
    input  logic [isa_pkg::XLEN-1:0]       rs1_data,
    input  logic [isa_pkg::XLEN-1:0]       rs2_data,
    output pipe_pkg::id_ex_t               id_ex
);
    import isa_pkg::*;
    import pipe_pkg::*;

    logic [XLEN-1:0] instr;
    logic [2:0]      funct3;
    logic [XLEN-1:0] imm_i;
    logic [XLEN-1:0] imm_u;
    logic [XLEN-1:0] imm_b;
    id_ex_t          dec;

    // Shared by OP and OP_IMM, alt selects SUB or SRA
    function automatic alu_op_e alu_decode(input logic [2:0] f3, input logic alt);
        case (f3)
            3'b000:  return alt ? SUB : ADD;
            3'b001:  return SLL;
            3'b010:  return SLT;
            3'b011:  return SLTU;
            3'b100:  return XOR;
            3'b101:  return alt ? SRA : SRL;
            3'b110:  return OR;
            default: return AND;
        endcase
    endfunction

    assign instr    = fetch.instr;
    assign funct3   = instr[14:12];
    assign rs1_addr = instr[19:15];
    assign rs2_addr = instr[24:20];

    // Immediate formats
    assign imm_i = {{20{instr[31]}}, instr[31:20]};
    assign imm_u = {instr[31:12], 12'd0};
    assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};

    always_comb
    begin
        dec.valid       = fetch.valid && !redirect.valid;
        dec.pc          = fetch.pc;
        dec.rs1         = rs1_addr;
        dec.rs2         = rs2_addr;
        dec.rs1_data    = rs1_data;
        dec.rs2_data    = rs2_data;
        dec.rd          = instr[11:7];
        dec.pred_taken  = fetch.pred_taken;
        dec.pred_target = fetch.pred_target;
        dec.alu_op      = ADD;
        dec.branch      = NONE;
        dec.imm         = imm_i;
        dec.use_imm     = 1'b0;
        dec.reg_write   = 1'b0;

        case (instr[6:0])
            OP:
            begin
                dec.alu_op    = alu_decode(funct3, instr[30]);
                dec.reg_write = 1'b1;
            end
            OP_IMM:
            begin
                dec.alu_op    = alu_decode(funct3, instr[30] && funct3 == 3'b101);
                dec.use_imm   = 1'b1;
                dec.reg_write = 1'b1;
            end
            LUI:
            begin
                dec.alu_op    = PASS_B;
                dec.imm       = imm_u;
                dec.use_imm   = 1'b1;
                dec.reg_write = 1'b1;
            end
            BRANCH:
            begin
                dec.imm = imm_b;
                case (funct3)
                    3'b000:  dec.branch = BEQ;
                    3'b001:  dec.branch = BNE;
                    3'b100:  dec.branch = BLT;
                    3'b101:  dec.branch = BGE;
                    3'b110:  dec.branch = BLTU;
                    3'b111:  dec.branch = BGEU;
                    default: dec.branch = NONE;
                endcase
            end
            // Anything else passes through as a no-op
            default: dec.reg_write = 1'b0;
        endcase
    end

    // ID/EX register
    always_ff @(posedge CPU_CLK or posedge CPU_RST)
    begin
        if (CPU_RST)
            id_ex.valid <= 1'b0;
        else
            id_ex <= dec;
    end

endmodule

// ==== hw/register_file.sv ====
`timescale 1ns/10ps

module register_file
(
    input  logic                           CPU_CLK,
    input  logic                           CPU_RST,
    input  pipe_pkg::ex_wb_t               wb,
    input  logic [isa_pkg::REG_ADDR_W-1:0] rs1_addr,
    input  logic [isa_pkg::REG_ADDR_W-1:0] rs2_addr,
    output logic [isa_pkg::XLEN-1:0]       rs1_data,
    output logic [isa_pkg::XLEN-1:0]       rs2_data,
    input  logic [isa_pkg::REG_ADDR_W-1:0] dbg_reg_addr,
    output logic [isa_pkg::XLEN-1:0]       dbg_reg_data
);
    import isa_pkg::*;

    logic [XLEN-1:0] regs [2**REG_ADDR_W];

    // x0 is zero, a same-cycle write is seen by the read
    function automatic logic [XLEN-1:0] read_port(input logic [REG_ADDR_W-1:0] addr);
        if (addr == '0)
            return '0;
        if (wb.valid && wb.rd == addr)
            return wb.result;
        return regs[addr];
    endfunction

    always_comb
    begin
        rs1_data = read_port(rs1_addr);
        rs2_data = read_port(rs2_addr);
    end

    assign dbg_reg_data = regs[dbg_reg_addr];

    always_ff @(posedge CPU_CLK or posedge CPU_RST)
    begin
        if (CPU_RST)
        begin
            for (int i = 0; i < 2**REG_ADDR_W; i++)
                regs[i] <= '0;
        end
        else if (wb.valid && wb.rd != '0)
            regs[wb.rd] <= wb.result;
    end

endmodule

// ==== hw/execute_unit.sv ====
`timescale 1ns/10ps

module execute_unit
(
    input  logic                 CPU_CLK,
    input  logic                 CPU_RST,
    input  pipe_pkg::id_ex_t     id_ex,
    output pipe_pkg::ex_wb_t     wb,
    output pipe_pkg::redirect_t  redirect,
    output pipe_pkg::bp_update_t bp_update
);
    import isa_pkg::*;

    logic [XLEN-1:0] op_a;
    logic [XLEN-1:0] op_b;
    logic [XLEN-1:0] alu_b;
    logic [XLEN-1:0] alu_out;
    logic [XLEN-1:0] pc_plus4;
    logic [XLEN-1:0] branch_target;
    logic [XLEN-1:0] actual_next;
    logic [XLEN-1:0] pred_next;
    logic            taken;
    logic            mispredict;

    // ------------------------------
    // Forwarding from EX/WB
    // ------------------------------
    assign op_a = (wb.valid && wb.rd != '0 && wb.rd == id_ex.rs1) ? wb.result : id_ex.rs1_data;
    assign op_b = (wb.valid && wb.rd != '0 && wb.rd == id_ex.rs2) ? wb.result : id_ex.rs2_data;

    assign alu_b = id_ex.use_imm ? id_ex.imm : op_b;

    always_comb
    begin
        case (id_ex.alu_op)
            ADD:     alu_out = op_a + alu_b;
            SUB:     alu_out = op_a - alu_b;
            AND:     alu_out = op_a & alu_b;
            OR:      alu_out = op_a | alu_b;
            XOR:     alu_out = op_a ^ alu_b;
            SLT:     alu_out = {{(XLEN-1){1'b0}}, $signed(op_a) < $signed(alu_b)};
            SLTU:    alu_out = {{(XLEN-1){1'b0}}, op_a < alu_b};
            SLL:     alu_out = op_a << alu_b[4:0];
            SRL:     alu_out = op_a >> alu_b[4:0];
            SRA:     alu_out = $unsigned($signed(op_a) >>> alu_b[4:0]);
            default: alu_out = alu_b;
        endcase
    end

    // ------------------------------
    // Branch resolution
    // ------------------------------
    always_comb
    begin
        case (id_ex.branch)
            BEQ:     taken = op_a == op_b;
            BNE:     taken = op_a != op_b;
            BLT:     taken = $signed(op_a) < $signed(op_b);
            BGE:     taken = $signed(op_a) >= $signed(op_b);
            BLTU:    taken = op_a < op_b;
            BGEU:    taken = op_a >= op_b;
            default: taken = 1'b0;
        endcase
    end

    assign pc_plus4      = id_ex.pc + 32'd4;
    assign branch_target = id_ex.pc + id_ex.imm;
    assign actual_next   = taken ? branch_target : pc_plus4;
    assign pred_next     = id_ex.pred_taken ? id_ex.pred_target : pc_plus4;
    // Also catches a stale taken prediction on a non-branch
    assign mispredict    = actual_next != pred_next;

    always_comb
    begin
        redirect.valid = id_ex.valid && mispredict;
        redirect.target = actual_next;

        bp_update.valid      = id_ex.valid && id_ex.branch != NONE;
        bp_update.pc         = id_ex.pc;
        bp_update.taken      = taken;
        bp_update.target     = branch_target;
        bp_update.mispredict = mispredict;
    end

    // EX/WB register
    always_ff @(posedge CPU_CLK or posedge CPU_RST)
    begin
        if (CPU_RST)
            wb.valid <= 1'b0;
        else
        begin
            wb.valid  <= id_ex.valid && id_ex.reg_write;
            wb.rd     <= id_ex.rd;
            wb.result <= alu_out;
        end
    end

endmodule

// ==== hw/rv32i_core.sv ====
`timescale 1ns/10ps

module rv32i_core
(
    input  logic                           CPU_CLK,
    input  logic                           CPU_RST,
    input  pipe_pkg::imem_write_t          imem_wr,
    input  logic [isa_pkg::REG_ADDR_W-1:0] dbg_reg_addr,
    output logic [isa_pkg::XLEN-1:0]       dbg_reg_data,
    output logic [31:0]                    branch_count,
    output logic [31:0]                    mispredict_count
);
    import isa_pkg::*;
    import pipe_pkg::*;

    fetch_t                fetch;
    id_ex_t                id_ex;
    ex_wb_t                wb;
    redirect_t             redirect;
    bp_update_t            bp_update;
    logic [REG_ADDR_W-1:0] rs1_addr;
    logic [REG_ADDR_W-1:0] rs2_addr;
    logic [XLEN-1:0]       rs1_data;
    logic [XLEN-1:0]       rs2_data;

    fetch_unit fetch_unit_i
    (
        .CPU_CLK          (CPU_CLK),
        .CPU_RST          (CPU_RST),
        .imem_wr          (imem_wr),
        .redirect         (redirect),
        .bp_update        (bp_update),
        .fetch            (fetch),
        .branch_count     (branch_count),
        .mispredict_count (mispredict_count)
    );

    decode_unit decode_unit_i
    (
        .CPU_CLK  (CPU_CLK),
        .CPU_RST  (CPU_RST),
        .fetch    (fetch),
        .redirect (redirect),
        .rs1_addr (rs1_addr),
        .rs2_addr (rs2_addr),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .id_ex    (id_ex)
    );

    // Written from the EX/WB register, which is the WB stage
    register_file register_file_i
    (
        .CPU_CLK      (CPU_CLK),
        .CPU_RST      (CPU_RST),
        .wb           (wb),
        .rs1_addr     (rs1_addr),
        .rs2_addr     (rs2_addr),
        .rs1_data     (rs1_data),
        .rs2_data     (rs2_data),
        .dbg_reg_addr (dbg_reg_addr),
        .dbg_reg_data (dbg_reg_data)
    );

    execute_unit execute_unit_i
    (
        .CPU_CLK   (CPU_CLK),
        .CPU_RST   (CPU_RST),
        .id_ex     (id_ex),
        .wb        (wb),
        .redirect  (redirect),
        .bp_update (bp_update)
    );

endmodule

// ==== test/rv32i_core_checker.sv ====
`timescale 1ns/10ps

module rv32i_core_checker
(
    input  logic                           CPU_CLK,
    input  logic [isa_pkg::XLEN-1:0]       dbg_reg_data,
    input  logic [31:0]                    branch_count,
    input  logic [31:0]                    mispredict_count,
    output logic [isa_pkg::REG_ADDR_W-1:0] dbg_reg_addr
);
    import isa_pkg::*;

    int error_count;

    initial
    begin
        dbg_reg_addr = '0;
        error_count  = 0;
    end

    // Entered on a falling edge, value taken one cycle later
    task automatic read_reg(input logic [REG_ADDR_W-1:0] addr, output logic [XLEN-1:0] value);
        dbg_reg_addr = addr;
        @(negedge CPU_CLK);
        value = dbg_reg_data;
    endtask

    task automatic expect_reg(input logic [REG_ADDR_W-1:0] addr, input logic [XLEN-1:0] expected);
        logic [XLEN-1:0] value;
        read_reg(addr, value);
        if (value !== expected)
        begin
            $display("Error: dbg_reg_data (x%0d) = %h, expected %h", addr, value, expected);
            error_count++;
        end
    endtask

    // Counters only move on posedges, stable here
    task automatic verify_counters(input logic [31:0] exp_branches,
                                   input logic [31:0] exp_mispredicts);
        if (branch_count !== exp_branches)
        begin
            $display("Error: branch_count = %h, expected %h", branch_count, exp_branches);
            error_count++;
        end
        if (mispredict_count !== exp_mispredicts)
        begin
            $display("Error: mispredict_count = %h, expected %h",
                     mispredict_count, exp_mispredicts);
            error_count++;
        end
    endtask

endmodule

// ==== test/rv32i_core_tb.sv ====
`timescale 1ns/10ps

module rv32i_core_tb;
    import pipe_pkg::*;

    localparam int          NUM_PROGS    = 5;
    localparam int          NUM_RUNS     = 6;
    localparam int          RESET_CYCLES = 10;
    // One word is written per reset cycle
    localparam int          PROG_WORDS   = RESET_CYCLES;
    localparam int          NUM_REGS_CHK = 10;
    localparam int          MAX_POLL     = 2000;
    localparam logic [31:0] MARKER       = 32'h0000_05a5;

    logic        CPU_CLK;
    logic        CPU_RST;
    imem_write_t imem_wr;
    logic [4:0]  dbg_reg_addr;
    logic [31:0] dbg_reg_data;
    logic [31:0] branch_count;
    logic [31:0] mispredict_count;

    // Program table with the expected x0..x9 and counter values
    logic [31:0] prog_words [NUM_PROGS][PROG_WORDS];
    logic [31:0] exp_regs [NUM_PROGS][NUM_REGS_CHK];
    logic [31:0] exp_branches [NUM_PROGS];
    logic [31:0] exp_mispredicts [NUM_PROGS];
    int          timeouts;

    initial
        CPU_CLK = 1'b0;

    always
        #50 CPU_CLK = ~CPU_CLK;

    rv32i_core rv32i_core_i
    (
        .CPU_CLK          (CPU_CLK),
        .CPU_RST          (CPU_RST),
        .imem_wr          (imem_wr),
        .dbg_reg_addr     (dbg_reg_addr),
        .dbg_reg_data     (dbg_reg_data),
        .branch_count     (branch_count),
        .mispredict_count (mispredict_count)
    );

    rv32i_core_checker rv32i_core_checker_i
    (
        .CPU_CLK          (CPU_CLK),
        .dbg_reg_data     (dbg_reg_data),
        .branch_count     (branch_count),
        .mispredict_count (mispredict_count),
        .dbg_reg_addr     (dbg_reg_addr)
    );

    // ------------------------------
    // RV32I instruction formats
    // ------------------------------
    function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3,
                                           input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
                                           input logic [2:0] f3, input logic [4:0] rd);
        return {imm, rs1, f3, rd, 7'b0010011};
    endfunction

    function automatic logic [31:0] u_type(input logic [19:0] imm, input logic [4:0] rd);
        return {imm, rd, 7'b0110111};
    endfunction

    function automatic logic [31:0] b_type(input logic [12:0] off, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b1100011};
    endfunction

    task automatic build_table();
        for (int p = 0; p < NUM_PROGS; p++)
        begin
            for (int w = 0; w < PROG_WORDS; w++)
                prog_words[p][w] = 32'h0;
            for (int r = 0; r < NUM_REGS_CHK; r++)
                exp_regs[p][r] = 32'h0;
            exp_branches[p]    = 32'd0;
            exp_mispredicts[p] = 32'd0;
        end

        // Dependent ALU chain
        prog_words[0][0] = i_type(12'd5, 5'd0, 3'b000, 5'd1);
        prog_words[0][1] = i_type(12'hffd, 5'd0, 3'b000, 5'd2);
        prog_words[0][2] = r_type(7'h20, 5'd2, 5'd1, 3'b000, 5'd3);
        prog_words[0][3] = i_type(12'd3, 5'd3, 3'b001, 5'd4);
        prog_words[0][4] = r_type(7'h20, 5'd1, 5'd2, 3'b101, 5'd5);
        prog_words[0][5] = i_type(12'd28, 5'd2, 3'b101, 5'd6);
        prog_words[0][6] = r_type(7'h00, 5'd1, 5'd2, 3'b010, 5'd7);
        prog_words[0][7] = r_type(7'h00, 5'd1, 5'd2, 3'b011, 5'd8);
        prog_words[0][8] = u_type(20'h12345, 5'd9);
        prog_words[0][9] = i_type(MARKER[11:0], 5'd0, 3'b000, 5'd31);
        exp_regs[0][1] = 32'h0000_0005;
        exp_regs[0][2] = 32'hffff_fffd;
        exp_regs[0][3] = 32'h0000_0008;
        exp_regs[0][4] = 32'h0000_0040;
        exp_regs[0][5] = 32'hffff_ffff;
        exp_regs[0][6] = 32'h0000_000f;
        exp_regs[0][7] = 32'h0000_0001;
        exp_regs[0][9] = 32'h1234_5000;

        // Logic ops and writes aimed at x0
        prog_words[1][0] = u_type(20'habcde, 5'd1);
        prog_words[1][1] = i_type(12'h123, 5'd1, 3'b110, 5'd1);
        prog_words[1][2] = i_type(12'd7, 5'd0, 3'b000, 5'd0);
        prog_words[1][3] = r_type(7'h00, 5'd1, 5'd1, 3'b000, 5'd0);
        prog_words[1][4] = r_type(7'h00, 5'd1, 5'd0, 3'b000, 5'd2);
        prog_words[1][5] = i_type(12'hfff, 5'd1, 3'b100, 5'd3);
        prog_words[1][6] = r_type(7'h00, 5'd3, 5'd1, 3'b111, 5'd4);
        prog_words[1][7] = r_type(7'h00, 5'd3, 5'd1, 3'b110, 5'd5);
        prog_words[1][8] = i_type(12'h404, 5'd1, 3'b101, 5'd6);
        prog_words[1][9] = i_type(MARKER[11:0], 5'd0, 3'b000, 5'd31);
        exp_regs[1][1] = 32'habcd_e123;
        exp_regs[1][2] = 32'habcd_e123;
        exp_regs[1][3] = 32'h5432_1edc;
        exp_regs[1][5] = 32'hffff_ffff;
        exp_regs[1][6] = 32'hfabc_de12;

        // Backward BNE loop, body runs three times
        prog_words[2][0] = i_type(12'd3, 5'd0, 3'b000, 5'd2);
        prog_words[2][1] = i_type(12'd1, 5'd1, 3'b000, 5'd1);
        prog_words[2][2] = b_type(13'h1ffc, 5'd2, 5'd1, 3'b001);
        prog_words[2][3] = i_type(MARKER[11:0], 5'd0, 3'b000, 5'd31);
        exp_regs[2][1]     = 32'd3;
        exp_regs[2][2]     = 32'd3;
        exp_branches[2]    = 32'd3;
        exp_mispredicts[2] = 32'd2;

        // New not-taken BEQ, then a taken BNE over two shadow words
        prog_words[3][0] = i_type(12'd1, 5'd0, 3'b000, 5'd1);
        prog_words[3][1] = i_type(12'd2, 5'd0, 3'b000, 5'd2);
        prog_words[3][2] = b_type(13'd8, 5'd2, 5'd1, 3'b000);
        prog_words[3][3] = i_type(12'd7, 5'd0, 3'b000, 5'd3);
        prog_words[3][4] = b_type(13'd12, 5'd2, 5'd1, 3'b001);
        prog_words[3][5] = i_type(12'd9, 5'd0, 3'b000, 5'd4);
        prog_words[3][6] = i_type(12'd9, 5'd0, 3'b000, 5'd5);
        prog_words[3][7] = i_type(12'd4, 5'd0, 3'b000, 5'd6);
        prog_words[3][8] = i_type(MARKER[11:0], 5'd0, 3'b000, 5'd31);
        exp_regs[3][1]     = 32'd1;
        exp_regs[3][2]     = 32'd2;
        exp_regs[3][3]     = 32'd7;
        exp_regs[3][6]     = 32'd4;
        exp_branches[3]    = 32'd2;
        exp_mispredicts[3] = 32'd1;

        // BLT taken and BLTU not taken on -1 versus 1
        prog_words[4][0] = i_type(12'hfff, 5'd0, 3'b000, 5'd1);
        prog_words[4][1] = i_type(12'd1, 5'd0, 3'b000, 5'd2);
        prog_words[4][2] = b_type(13'd8, 5'd2, 5'd1, 3'b100);
        prog_words[4][3] = i_type(12'd1, 5'd0, 3'b000, 5'd3);
        prog_words[4][4] = b_type(13'd8, 5'd2, 5'd1, 3'b110);
        prog_words[4][5] = i_type(12'd1, 5'd0, 3'b000, 5'd4);
        prog_words[4][6] = i_type(MARKER[11:0], 5'd0, 3'b000, 5'd31);
        exp_regs[4][1]     = 32'hffff_ffff;
        exp_regs[4][2]     = 32'd1;
        exp_regs[4][4]     = 32'd1;
        exp_branches[4]    = 32'd2;
        exp_mispredicts[4] = 32'd1;
    endtask

    // ------------------------------
    // Run control
    // ------------------------------
    task automatic load_program(input int p);
        CPU_RST = 1'b1;
        for (int cyc = 0; cyc < RESET_CYCLES; cyc++)
        begin
            imem_wr.en   = 1'b1;
            imem_wr.addr = 8'(cyc);
            imem_wr.data = prog_words[p][cyc];
            @(negedge CPU_CLK);
        end
        imem_wr = '0;
        CPU_RST = 1'b0;
    endtask

    task automatic wait_marker(output logic found);
        logic [31:0] value;
        found = 1'b0;
        for (int cyc = 0; cyc < MAX_POLL && !found; cyc++)
        begin
            rv32i_core_checker_i.read_reg(5'd31, value);
            found = (value == MARKER);
        end
    endtask

    initial
    begin
        int   p;
        logic found;
        CPU_RST  = 1'b1;
        imem_wr  = '0;
        timeouts = 0;
        build_table();
        @(negedge CPU_CLK);

        for (int run = 0; run < NUM_RUNS; run++)
        begin
            // Last run repeats the loop program after a fresh reset
            p = (run == NUM_RUNS - 1) ? 2 : run;
            load_program(p);
            wait_marker(found);
            if (!found)
            begin
                $display("Timeout: program %0d never wrote its end marker to x31", p);
                timeouts++;
            end
            else
            begin
                for (int r = 0; r < NUM_REGS_CHK; r++)
                    rv32i_core_checker_i.expect_reg(5'(r), exp_regs[p][r]);
                rv32i_core_checker_i.verify_counters(exp_branches[p], exp_mispredicts[p]);
            end
        end

        $display("Summary: %0d errors, %0d timeouts",
                 rv32i_core_checker_i.error_count, timeouts);
        if (rv32i_core_checker_i.error_count == 0 && timeouts == 0)
            $display("Test passed");
        else
            $display("Test failed");
        $finish;
    end

endmodule

// ==== filelist.f ====
hw/isa_pkg.sv
hw/pipe_pkg.sv
hw/branch_predictor.sv
hw/fetch_unit.sv
hw/decode_unit.sv
hw/register_file.sv
hw/execute_unit.sv
hw/rv32i_core.sv
test/rv32i_core_checker.sv
test/rv32i_core_tb.sv

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary -f filelist.f --top-module rv32i_core_tb -o rv32i_core_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/rv32i_core_sim)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "Test passed"; then
    exit 0
fi
exit 1
